// File: hw/tinker_pkg.sv
package tinker_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int LIT_W      = 12;
    localparam int MEM_BYTES  = 16384;
    localparam int MEM_ADDR_W = 14;

    localparam logic [XLEN-1:0] RESET_PC = 64'h2000;

    // Any code not listed here runs as a no-op
    typedef enum logic [4:0] {
        OP_AND     = 5'h00,
        OP_OR      = 5'h01,
        OP_XOR     = 5'h02,
        OP_NOT     = 5'h03,
        OP_SHFTR   = 5'h04,
        OP_SHFTRI  = 5'h05,
        OP_SHFTL   = 5'h06,
        OP_SHFTLI  = 5'h07,
        OP_BR      = 5'h08,
        OP_BRR     = 5'h09,
        OP_BRR_LIT = 5'h0A,
        OP_BRNZ    = 5'h0B,
        OP_BRGT    = 5'h0E,
        OP_HALT    = 5'h0F,
        OP_LOAD    = 5'h10,
        OP_MOV     = 5'h11,
        OP_MOVL    = 5'h12,
        OP_STORE   = 5'h13,
        OP_ADD     = 5'h18,
        OP_ADDI    = 5'h19,
        OP_SUB     = 5'h1A,
        OP_SUBI    = 5'h1B,
        OP_MUL     = 5'h1C,
        OP_DIV     = 5'h1D
    } opcode_t;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } stage_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs;
        logic [REG_ADDR_W-1:0]   rt;
        logic [XLEN-1:0]         literal;
        logic                    use_lit;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] mem_addr;
        logic [XLEN-1:0] mem_wdata;
        logic            mem_read;
        logic            mem_write;
    } alu_out_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
        logic [ILEN-1:0]       data;
    } load_port_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } store_event_t;

endpackage

// File: hw/tinker_alu.sv
`timescale 1ns/1ps

module tinker_alu (
    input  logic [tinker_pkg::XLEN-1:0] operand_a,
    input  logic [tinker_pkg::XLEN-1:0] operand_b,
    input  logic [tinker_pkg::XLEN-1:0] operand_d,
    input  logic [tinker_pkg::XLEN-1:0] pc,
    input  tinker_pkg::opcode_t         opcode,
    output tinker_pkg::alu_out_t        alu_out
);

    logic [5:0]                  shamt;
    logic [tinker_pkg::XLEN-1:0] pc_plus4;

    assign shamt    = operand_b[5:0];
    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        alu_out.result    = '0;
        alu_out.next_pc   = pc_plus4;
        alu_out.mem_addr  = '0;
        alu_out.mem_wdata = '0;
        alu_out.mem_read  = 1'b0;
        alu_out.mem_write = 1'b0;
        case (opcode)
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI: begin
                alu_out.result = operand_a + operand_b;
            end
            tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI: begin
                alu_out.result = operand_a - operand_b;
            end
            tinker_pkg::OP_MUL: alu_out.result = operand_a * operand_b;
            tinker_pkg::OP_DIV: begin
                // Divide by zero yields 0
                alu_out.result = (operand_b == '0) ? '0 : operand_a / operand_b;
            end
            tinker_pkg::OP_AND: alu_out.result = operand_a & operand_b;
            tinker_pkg::OP_OR:  alu_out.result = operand_a | operand_b;
            tinker_pkg::OP_XOR: alu_out.result = operand_a ^ operand_b;
            tinker_pkg::OP_NOT: alu_out.result = ~operand_a;
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI: begin
                alu_out.result = operand_a >> shamt;
            end
            tinker_pkg::OP_SHFTL, tinker_pkg::OP_SHFTLI: begin
                alu_out.result = operand_a << shamt;
            end
            tinker_pkg::OP_MOV: alu_out.result = operand_a;
            tinker_pkg::OP_MOVL: begin
                alu_out.result = {operand_a[63:12], operand_b[11:0]};
            end
            tinker_pkg::OP_BR:      alu_out.next_pc = operand_d;
            tinker_pkg::OP_BRR:     alu_out.next_pc = pc + operand_d;
            tinker_pkg::OP_BRR_LIT: alu_out.next_pc = pc + operand_b;
            tinker_pkg::OP_BRNZ: begin
                alu_out.next_pc = (operand_a != '0) ? operand_d : pc_plus4;
            end
            tinker_pkg::OP_BRGT: begin
                // Unsigned compare
                alu_out.next_pc = (operand_a > operand_b) ? operand_d : pc_plus4;
            end
            tinker_pkg::OP_LOAD: begin
                alu_out.mem_addr = operand_a + operand_b;
                alu_out.mem_read = 1'b1;
            end
            tinker_pkg::OP_STORE: begin
                alu_out.mem_addr  = operand_d + operand_b;
                alu_out.mem_wdata = operand_a;
                alu_out.mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hw/tinker_regfile.sv
`timescale 1ns/1ps

module tinker_regfile (
    input  logic                        clk,
    input  logic                        reset,
    input  tinker_pkg::decoded_t        decoded,
    input  logic                        reg_read,
    input  logic                        reg_write,
    input  logic [tinker_pkg::XLEN-1:0] wdata,
    output logic [tinker_pkg::XLEN-1:0] operand_a,
    output logic [tinker_pkg::XLEN-1:0] operand_b,
    output logic [tinker_pkg::XLEN-1:0] operand_d
);

    logic [tinker_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[decoded.rd] <= wdata;
        end
    end

    // Operand latch at the end of DECODE
    always_ff @(posedge clk) begin
        if (reg_read) begin
            operand_a <= regs[decoded.rs];
            operand_b <= decoded.use_lit ? decoded.literal : regs[decoded.rt];
            operand_d <= regs[decoded.rd];
        end
    end

endmodule

// File: hw/tinker_memory.sv
`timescale 1ns/1ps

module tinker_memory (
    input  logic                         clk,
    input  tinker_pkg::load_port_t       prog_load,
    input  logic [tinker_pkg::XLEN-1:0]  pc,
    output logic [tinker_pkg::ILEN-1:0]  instr,
    input  logic                         mem_strobe,
    input  tinker_pkg::alu_out_t         mem_req,
    output logic [tinker_pkg::XLEN-1:0]  rdata,
    output tinker_pkg::store_event_t     store_event
);

    logic [7:0] mem [tinker_pkg::MEM_BYTES];

    logic [tinker_pkg::MEM_ADDR_W-1:0] fetch_addr;
    logic [tinker_pkg::MEM_ADDR_W-1:0] data_addr;
    logic                              do_write;

    // Addresses wrap at the memory size
    assign fetch_addr = pc[tinker_pkg::MEM_ADDR_W-1:0];
    assign data_addr  = mem_req.mem_addr[tinker_pkg::MEM_ADDR_W-1:0];
    assign do_write   = mem_strobe && mem_req.mem_write;

    always_ff @(posedge clk) begin
        instr <= {mem[fetch_addr + 2'd3], mem[fetch_addr + 2'd2],
                  mem[fetch_addr + 2'd1], mem[fetch_addr]};
    end

    always_ff @(posedge clk) begin
        if (prog_load.valid) begin
            for (int k = 0; k < 4; k++) begin
                mem[prog_load.addr + k[tinker_pkg::MEM_ADDR_W-1:0]] <=
                    prog_load.data[8*k +: 8];
            end
        end
        if (do_write) begin
            for (int k = 0; k < 8; k++) begin
                mem[data_addr + k[tinker_pkg::MEM_ADDR_W-1:0]] <=
                    mem_req.mem_wdata[8*k +: 8];
            end
        end
    end

    // Little-endian 8-byte read
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rdata[8*i +: 8] = mem[data_addr + i[tinker_pkg::MEM_ADDR_W-1:0]];
        end
    end

    assign store_event.valid = do_write;
    assign store_event.addr  = data_addr;
    assign store_event.data  = mem_req.mem_wdata;

endmodule

// File: hw/tinker_sequencer.sv
`timescale 1ns/1ps

module tinker_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [tinker_pkg::ILEN-1:0] instr,
    input  tinker_pkg::alu_out_t        alu_out,
    input  logic [tinker_pkg::XLEN-1:0] mem_rdata,
    input  logic [tinker_pkg::XLEN-1:0] operand_a,
    input  logic [tinker_pkg::XLEN-1:0] operand_b,
    input  logic [tinker_pkg::XLEN-1:0] operand_d,
    output logic [tinker_pkg::XLEN-1:0] pc,
    output tinker_pkg::decoded_t        decoded,
    output logic                        reg_read,
    output logic                        reg_write,
    output logic [tinker_pkg::XLEN-1:0] reg_wdata,
    output logic [tinker_pkg::XLEN-1:0] alu_a,
    output logic [tinker_pkg::XLEN-1:0] alu_b,
    output logic [tinker_pkg::XLEN-1:0] alu_d,
    output logic                        mem_strobe,
    output tinker_pkg::alu_out_t        mem_req,
    output logic                        halted
);

    tinker_pkg::stage_t          stage;
    tinker_pkg::stage_t          stage_next;
    logic [tinker_pkg::ILEN-1:0] ir;
    logic [tinker_pkg::ILEN-1:0] instr_word;
    tinker_pkg::opcode_t         op;
    tinker_pkg::alu_out_t        alu_q;

    // Opcodes that end in a register write
    function automatic logic writes_rd(input tinker_pkg::opcode_t code);
        case (code)
            tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR,
            tinker_pkg::OP_NOT, tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI,
            tinker_pkg::OP_SHFTL, tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV,
            tinker_pkg::OP_MOVL, tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI,
            tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI, tinker_pkg::OP_MUL,
            tinker_pkg::OP_DIV: writes_rd = 1'b1;
            default:            writes_rd = 1'b0;
        endcase
    endfunction

    // Fetched word arrives from memory during DECODE
    assign instr_word = (stage == tinker_pkg::DECODE) ? instr : ir;
    assign op         = tinker_pkg::opcode_t'(instr_word[31:27]);

    always_comb begin
        decoded.opcode  = op;
        decoded.rd      = instr_word[26:22];
        decoded.rs      = instr_word[21:17];
        decoded.rt      = instr_word[16:12];
        decoded.literal = {{(tinker_pkg::XLEN-tinker_pkg::LIT_W){1'b0}},
                           instr_word[tinker_pkg::LIT_W-1:0]};
        decoded.use_lit = 1'b0;
        case (op)
            // Immediate forms read and write rd
            tinker_pkg::OP_ADDI, tinker_pkg::OP_SUBI, tinker_pkg::OP_SHFTRI,
            tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOVL: begin
                decoded.rs      = instr_word[26:22];
                decoded.use_lit = 1'b1;
            end
            tinker_pkg::OP_LOAD, tinker_pkg::OP_STORE, tinker_pkg::OP_BRR_LIT: begin
                decoded.use_lit = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        stage_next = stage;
        case (stage)
            tinker_pkg::FETCH:  stage_next = tinker_pkg::DECODE;
            tinker_pkg::DECODE: stage_next = tinker_pkg::EXECUTE;
            tinker_pkg::EXECUTE: begin
                if (op == tinker_pkg::OP_HALT) begin
                    stage_next = tinker_pkg::HALTED;
                end else if (alu_out.mem_read || alu_out.mem_write) begin
                    stage_next = tinker_pkg::MEMORY;
                end else if (writes_rd(op)) begin
                    stage_next = tinker_pkg::WRITEBACK;
                end else begin
                    stage_next = tinker_pkg::FETCH;
                end
            end
            tinker_pkg::MEMORY: begin
                stage_next = alu_q.mem_read ? tinker_pkg::WRITEBACK : tinker_pkg::FETCH;
            end
            tinker_pkg::WRITEBACK: stage_next = tinker_pkg::FETCH;
            tinker_pkg::HALTED:    stage_next = tinker_pkg::HALTED;
            default:               stage_next = tinker_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= tinker_pkg::FETCH;
            pc    <= tinker_pkg::RESET_PC;
        end else begin
            stage <= stage_next;
            if (stage == tinker_pkg::EXECUTE) begin
                pc <= alu_out.next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage == tinker_pkg::DECODE) begin
            ir <= instr;
        end
        if (stage == tinker_pkg::EXECUTE) begin
            alu_q <= alu_out;
        end
    end

    assign alu_a = operand_a;
    assign alu_b = operand_b;
    assign alu_d = operand_d;

    assign reg_read   = (stage == tinker_pkg::DECODE);
    assign reg_write  = (stage == tinker_pkg::WRITEBACK);
    assign reg_wdata  = alu_q.mem_read ? mem_rdata : alu_q.result;
    assign mem_strobe = (stage == tinker_pkg::MEMORY);
    assign mem_req    = alu_q;
    assign halted     = (stage == tinker_pkg::HALTED);

endmodule

// File: hw/tinker_cpu.sv
`timescale 1ns/1ps

module tinker_cpu (
    input  logic                    clk,
    input  logic                    reset,
    input  tinker_pkg::load_port_t  prog_load,
    output logic                    halted,
    output tinker_pkg::store_event_t store_event
);

    logic [tinker_pkg::XLEN-1:0] pc;
    logic [tinker_pkg::ILEN-1:0] instr;
    tinker_pkg::decoded_t        decoded;
    logic                        reg_read;
    logic                        reg_write;
    logic [tinker_pkg::XLEN-1:0] reg_wdata;
    logic [tinker_pkg::XLEN-1:0] operand_a;
    logic [tinker_pkg::XLEN-1:0] operand_b;
    logic [tinker_pkg::XLEN-1:0] operand_d;
    logic [tinker_pkg::XLEN-1:0] alu_a;
    logic [tinker_pkg::XLEN-1:0] alu_b;
    logic [tinker_pkg::XLEN-1:0] alu_d;
    tinker_pkg::alu_out_t        alu_out;
    logic                        mem_strobe;
    tinker_pkg::alu_out_t        mem_req;
    logic [tinker_pkg::XLEN-1:0] mem_rdata;

    tinker_sequencer i_tinker_sequencer (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .alu_out    (alu_out),
        .mem_rdata  (mem_rdata),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .operand_d  (operand_d),
        .pc         (pc),
        .decoded    (decoded),
        .reg_read   (reg_read),
        .reg_write  (reg_write),
        .reg_wdata  (reg_wdata),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_d      (alu_d),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req),
        .halted     (halted)
    );

    tinker_regfile i_tinker_regfile (
        .clk       (clk),
        .reset     (reset),
        .decoded   (decoded),
        .reg_read  (reg_read),
        .reg_write (reg_write),
        .wdata     (reg_wdata),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .operand_d (operand_d)
    );

    tinker_alu i_tinker_alu (
        .operand_a (alu_a),
        .operand_b (alu_b),
        .operand_d (alu_d),
        .pc        (pc),
        .opcode    (decoded.opcode),
        .alu_out   (alu_out)
    );

    tinker_memory i_tinker_memory (
        .clk         (clk),
        .prog_load   (prog_load),
        .pc          (pc),
        .instr       (instr),
        .mem_strobe  (mem_strobe),
        .mem_req     (mem_req),
        .rdata       (mem_rdata),
        .store_event (store_event)
    );

endmodule

// File: dv/tinker_programs.svh
`ifndef TINKER_PROGRAMS_SVH
`define TINKER_PROGRAMS_SVH

localparam int NPROG = 8;

logic [31:0] code      [NPROG][16];
int          code_len  [NPROG];
logic [13:0] data_addr [NPROG][2];
logic [31:0] data_word [NPROG][2];
int          data_cnt  [NPROG];
logic [13:0] exp_addr  [NPROG][8];
logic [63:0] exp_data  [NPROG][8];
int          exp_cnt   [NPROG];

// Opcode in the top five bits followed by rd, rs, rt and a 12-bit literal
task automatic put_instr(input int p, input logic [4:0] op, input logic [4:0] rd,
                         input logic [4:0] rs, input logic [4:0] rt,
                         input logic [11:0] lit);
    code[p][code_len[p]] = {op, rd, rs, rt, lit};
    code_len[p]++;
endtask

task automatic put_data(input int p, input logic [13:0] addr, input logic [31:0] word);
    data_addr[p][data_cnt[p]] = addr;
    data_word[p][data_cnt[p]] = word;
    data_cnt[p]++;
endtask

task automatic expect_store(input int p, input logic [13:0] addr, input logic [63:0] data);
    exp_addr[p][exp_cnt[p]] = addr;
    exp_data[p][exp_cnt[p]] = data;
    exp_cnt[p]++;
endtask

task automatic build_programs;
    for (int p = 0; p < NPROG; p++) begin
        code_len[p] = 0;
        data_cnt[p] = 0;
        exp_cnt[p]  = 0;
    end
    // Halt only
    put_instr(0, 5'h0F, 0, 0, 0, 12'h000);
    // Register arithmetic with r2 = 0x123456 and r3 = 0x10
    put_instr(1, 5'h12, 2, 0, 0, 12'h123);
    put_instr(1, 5'h07, 2, 0, 0, 12'h00C);
    put_instr(1, 5'h12, 2, 0, 0, 12'h456);
    put_instr(1, 5'h12, 3, 0, 0, 12'h010);
    put_instr(1, 5'h18, 4, 2, 3, 12'h000);
    put_instr(1, 5'h13, 0, 4, 0, 12'h100);
    put_instr(1, 5'h1A, 5, 2, 3, 12'h000);
    put_instr(1, 5'h13, 0, 5, 0, 12'h108);
    put_instr(1, 5'h1C, 6, 2, 3, 12'h000);
    put_instr(1, 5'h13, 0, 6, 0, 12'h110);
    put_instr(1, 5'h1D, 7, 2, 3, 12'h000);
    put_instr(1, 5'h13, 0, 7, 0, 12'h118);
    put_instr(1, 5'h1D, 8, 2, 0, 12'h000);
    put_instr(1, 5'h13, 0, 8, 0, 12'h120);
    put_instr(1, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(1, 14'h100, 64'h123466);
    expect_store(1, 14'h108, 64'h123446);
    expect_store(1, 14'h110, 64'h1234560);
    expect_store(1, 14'h118, 64'h12345);
    expect_store(1, 14'h120, 64'h0);
    // Logic and right shift with r3 = 0xF0F so the shift is 15
    put_instr(2, 5'h12, 2, 0, 0, 12'h123);
    put_instr(2, 5'h07, 2, 0, 0, 12'h00C);
    put_instr(2, 5'h12, 2, 0, 0, 12'h456);
    put_instr(2, 5'h12, 3, 0, 0, 12'hF0F);
    put_instr(2, 5'h00, 4, 2, 3, 12'h000);
    put_instr(2, 5'h13, 0, 4, 0, 12'h100);
    put_instr(2, 5'h01, 5, 2, 3, 12'h000);
    put_instr(2, 5'h13, 0, 5, 0, 12'h108);
    put_instr(2, 5'h02, 6, 2, 3, 12'h000);
    put_instr(2, 5'h13, 0, 6, 0, 12'h110);
    put_instr(2, 5'h03, 7, 2, 0, 12'h000);
    put_instr(2, 5'h13, 0, 7, 0, 12'h118);
    put_instr(2, 5'h04, 8, 2, 3, 12'h000);
    put_instr(2, 5'h13, 0, 8, 0, 12'h120);
    put_instr(2, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(2, 14'h100, 64'h406);
    expect_store(2, 14'h108, 64'h123F5F);
    expect_store(2, 14'h110, 64'h123B59);
    expect_store(2, 14'h118, 64'hFFFF_FFFF_FFED_CBA9);
    expect_store(2, 14'h120, 64'h24);
    // Immediate forms on rd and then a register left shift
    put_instr(3, 5'h12, 2, 0, 0, 12'h123);
    put_instr(3, 5'h07, 2, 0, 0, 12'h00C);
    put_instr(3, 5'h12, 2, 0, 0, 12'h456);
    put_instr(3, 5'h13, 0, 2, 0, 12'h100);
    put_instr(3, 5'h19, 2, 0, 0, 12'h0AA);
    put_instr(3, 5'h13, 0, 2, 0, 12'h108);
    put_instr(3, 5'h1B, 2, 0, 0, 12'h100);
    put_instr(3, 5'h13, 0, 2, 0, 12'h110);
    put_instr(3, 5'h05, 2, 0, 0, 12'h008);
    put_instr(3, 5'h13, 0, 2, 0, 12'h118);
    put_instr(3, 5'h12, 3, 0, 0, 12'h004);
    put_instr(3, 5'h06, 4, 2, 3, 12'h000);
    put_instr(3, 5'h13, 0, 4, 0, 12'h120);
    put_instr(3, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(3, 14'h100, 64'h123456);
    expect_store(3, 14'h108, 64'h123500);
    expect_store(3, 14'h110, 64'h123400);
    expect_store(3, 14'h118, 64'h1234);
    expect_store(3, 14'h120, 64'h12340);
    // Store and load back and store again plus a preloaded word at 0x180
    put_data(4, 14'h180, 32'hDEAD_BEEF);
    put_data(4, 14'h184, 32'h0BAD_F00D);
    put_instr(4, 5'h12, 2, 0, 0, 12'h7AB);
    put_instr(4, 5'h07, 2, 0, 0, 12'h010);
    put_instr(4, 5'h12, 2, 0, 0, 12'h123);
    put_instr(4, 5'h13, 0, 2, 0, 12'h100);
    put_instr(4, 5'h12, 3, 0, 0, 12'h100);
    put_instr(4, 5'h10, 4, 3, 0, 12'h000);
    put_instr(4, 5'h13, 3, 4, 0, 12'h040);
    put_instr(4, 5'h10, 5, 3, 0, 12'h080);
    put_instr(4, 5'h13, 0, 5, 0, 12'h1C0);
    put_instr(4, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(4, 14'h100, 64'h7AB0123);
    expect_store(4, 14'h140, 64'h7AB0123);
    expect_store(4, 14'h1C0, 64'h0BAD_F00D_DEAD_BEEF);
    // Relative jumps that each skip one marker store
    put_instr(5, 5'h12, 2, 0, 0, 12'h0AA);
    put_instr(5, 5'h0A, 0, 0, 0, 12'h008);
    put_instr(5, 5'h13, 0, 2, 0, 12'h100);
    put_instr(5, 5'h13, 0, 2, 0, 12'h108);
    put_instr(5, 5'h12, 3, 0, 0, 12'h008);
    put_instr(5, 5'h09, 3, 0, 0, 12'h000);
    put_instr(5, 5'h13, 0, 2, 0, 12'h110);
    put_instr(5, 5'h13, 0, 2, 0, 12'h118);
    put_instr(5, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(5, 14'h108, 64'hAA);
    expect_store(5, 14'h118, 64'hAA);
    // Absolute and conditional jumps with the target in r10
    put_instr(6, 5'h12, 10, 0, 0, 12'h200);
    put_instr(6, 5'h07, 10, 0, 0, 12'h004);
    put_instr(6, 5'h12, 10, 0, 0, 12'h014);
    put_instr(6, 5'h08, 10, 0, 0, 12'h000);
    put_instr(6, 5'h13, 0, 10, 0, 12'h100);
    put_instr(6, 5'h12, 10, 0, 0, 12'h020);
    put_instr(6, 5'h0B, 10, 10, 0, 12'h000);
    put_instr(6, 5'h13, 0, 10, 0, 12'h108);
    put_instr(6, 5'h0B, 10, 0, 0, 12'h000);
    put_instr(6, 5'h13, 0, 10, 0, 12'h110);
    put_instr(6, 5'h12, 10, 0, 0, 12'h034);
    put_instr(6, 5'h0E, 10, 10, 0, 12'h000);
    put_instr(6, 5'h13, 0, 10, 0, 12'h118);
    put_instr(6, 5'h0E, 10, 0, 10, 12'h000);
    put_instr(6, 5'h13, 0, 10, 0, 12'h120);
    put_instr(6, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(6, 14'h110, 64'h2020);
    expect_store(6, 14'h120, 64'h2034);
    // Dropped opcode 0x14 between two stores and then a register move
    put_instr(7, 5'h12, 2, 0, 0, 12'h055);
    put_instr(7, 5'h13, 0, 2, 0, 12'h100);
    put_instr(7, 5'h14, 2, 2, 2, 12'hFFF);
    put_instr(7, 5'h13, 0, 2, 0, 12'h108);
    put_instr(7, 5'h11, 3, 2, 0, 12'h000);
    put_instr(7, 5'h13, 0, 3, 0, 12'h110);
    put_instr(7, 5'h0F, 0, 0, 0, 12'h000);
    expect_store(7, 14'h100, 64'h55);
    expect_store(7, 14'h108, 64'h55);
    expect_store(7, 14'h110, 64'h55);
endtask

`endif

// File: dv/tinker_tb.sv
`timescale 1ns/1ps

module tinker_tb;

    logic                     clk;
    logic                     reset;
    tinker_pkg::load_port_t   prog_load;
    logic                     halted;
    tinker_pkg::store_event_t store_event;

    int          errors;
    int          cycles;
    int          limit;
    int          seed;
    logic [13:0] got_addr [$];
    logic [63:0] got_data [$];

    `include "tinker_programs.svh"

    tinker_cpu i_tinker_cpu (
        .clk         (clk),
        .reset       (reset),
        .prog_load   (prog_load),
        .halted      (halted),
        .store_event (store_event)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_word(input logic [13:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        prog_load.valid = 1'b1;
        prog_load.addr  = addr;
        prog_load.data  = data;
    endtask

    task automatic run_program(input int p);
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        // Random words under the data area expose stray loads
        for (int a = 0; a < 14'h200; a += 4) begin
            write_word(a[13:0], $random(seed));
        end
        for (int i = 0; i < data_cnt[p]; i++) begin
            write_word(data_addr[p][i], data_word[p][i]);
        end
        for (int i = 0; i < code_len[p]; i++) begin
            write_word(14'h2000 + 14'(4 * i), code[p][i]);
        end
        @(posedge clk);
        #2;
        prog_load.valid = 1'b0;
        @(negedge clk);
        check_value("halted", halted, 0);
        check_value("store_event.valid", store_event.valid, 0);
        @(posedge clk);
        #2;
        reset = 1'b0;
        got_addr.delete();
        got_data.delete();
        do begin
            @(negedge clk);
            if (store_event.valid) begin
                got_addr.push_back(store_event.addr);
                got_data.push_back(store_event.data);
            end
        end while (!halted);
        // Halt level holds and no store follows
        repeat (5) begin
            @(negedge clk);
            check_value("halted", halted, 1);
            check_value("store_event.valid", store_event.valid, 0);
        end
        check_value("store_count", got_addr.size(), exp_cnt[p]);
        for (int i = 0; i < exp_cnt[p] && i < got_addr.size(); i++) begin
            check_value("store_event.addr", got_addr[i], exp_addr[p][i]);
            check_value("store_event.data", got_data[i], exp_data[p][i]);
        end
    endtask

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles <= limit) begin
            @(posedge clk);
            if (!reset) begin
                cycles++;
            end
        end
        $display("timeout: the programs did not halt within %0d cycles", limit);
        $display("errors: %0d over %0d programs", errors, NPROG);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        prog_load = '0;
        errors    = 0;
        limit     = 0;
        seed      = 32'he53d_d38f;
        build_programs();
        for (int p = 0; p < NPROG; p++) begin
            limit += 5 * code_len[p] + 50;
        end
        for (int p = 0; p < NPROG; p++) begin
            run_program(p);
        end
        $display("errors: %0d over %0d programs", errors, NPROG);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+dv
hw/tinker_pkg.sv
hw/tinker_alu.sv
hw/tinker_regfile.sv
hw/tinker_memory.sv
hw/tinker_sequencer.sv
hw/tinker_cpu.sv
dv/tinker_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tinker_tb -f files.f -o tinker_sim \
    && ./obj_dir/tinker_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 \
    || grep -q "TB PASSED" sim.log && exit 0 \
    || exit 1
